// File: cmoving_avg.f
verilog/cavg_pkg.sv
verilog/moving_sum.sv
verilog/round_clip.sv
verilog/cmoving_avg.sv
sim/tb_cmoving_avg.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cmoving_avg testbench with Verilator.
# The exit status is the simulator's own, nonzero when the testbench fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert \
  --top-module tb_cmoving_avg \
  -f cmoving_avg.f \
  -Mdir obj_dir \
  -o tb_cmoving_avg
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_cmoving_avg
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit "$status"
fi

exit 0

// File: sim/tb_cmoving_avg.sv
`timescale 1ns/1ps

module tb_cmoving_avg import cavg_pkg::*; ();

  localparam int MAX_ROWS = 80;
  localparam logic [31:0] LCG_SEED = 32'hce42_9f56;

  logic    i_clk;
  logic    i_rst;
  logic    i_clear;
  len_t    i_len;
  logic    i_in_tvalid;
  logic    i_in_tlast;
  sample_t i_in_idata;
  sample_t i_in_qdata;
  logic    o_in_tready;
  logic    o_out_tvalid;
  logic    o_out_tlast;
  sample_t o_out_idata;
  sample_t o_out_qdata;
  logic    i_out_tready;

  // stimulus table
  string   tbl_name [MAX_ROWS];
  logic    tbl_clr  [MAX_ROWS];
  len_t    tbl_len  [MAX_ROWS];
  sample_t tbl_i    [MAX_ROWS];
  sample_t tbl_q    [MAX_ROWS];
  logic    tbl_last [MAX_ROWS];
  int      n_rows = 0;

  // expected outputs, in order
  string   exp_name [$];
  sample_t exp_i    [$];
  sample_t exp_q    [$];
  logic    exp_last [$];

  int mdl_len;  // model window length
  int mdl_i [$];
  int mdl_q [$];

  int          cycle = 0;
  int          timeout_lim = 1000000;
  int          acc_cyc;
  logic        bp_en = 1'b0;
  logic [31:0] lcg_state = LCG_SEED;

  string   mon_name;
  sample_t mon_i;
  sample_t mon_q;
  logic    mon_last;

  cmoving_avg u_cmoving_avg (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_clear      (i_clear),
    .i_len        (i_len),
    .i_in_tvalid  (i_in_tvalid),
    .i_in_tlast   (i_in_tlast),
    .i_in_idata   (i_in_idata),
    .i_in_qdata   (i_in_qdata),
    .o_in_tready  (o_in_tready),
    .o_out_tvalid (o_out_tvalid),
    .o_out_tlast  (o_out_tlast),
    .o_out_idata  (o_out_idata),
    .o_out_qdata  (o_out_qdata),
    .i_out_tready (i_out_tready)
  );

  initial i_clk = 1'b0;
  always #50 i_clk = ~i_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (exp !== act) begin
      abort_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic check_last(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      abort_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_cycle(input string name, input int exp, input int act);
    if (exp != act) begin
      abort_run($sformatf("Mismatch %s: expected edge %0d, actual edge %0d", name, exp, act));
    end
  endtask

  task automatic add_row(input string name, input int clr, input int len,
                         input int i_val, input int q_val, input int last);
    tbl_name[n_rows] = name;
    tbl_clr[n_rows]  = (clr != 0);
    tbl_len[n_rows]  = len_t'(len);
    tbl_i[n_rows]    = sample_t'(i_val);
    tbl_q[n_rows]    = sample_t'(q_val);
    tbl_last[n_rows] = (last != 0);
    n_rows++;
  endtask

  task automatic build_table();
    for (int k = 0; k < 8; k++) begin  // ramp through fill and slide
      add_row("fill_slide", (k == 0) ? 1 : 0, 4, 100 * (k + 1), -37 * (k + 1),
              (k == 3 || k == 7) ? 1 : 0);
    end
    add_row("len1", 1, 1, 1000, -3000, 0);
    add_row("len1", 0, 1, -1000, 3001, 1);
    add_row("len1", 0, 1, 24, -24, 0);
    for (int k = 0; k < 17; k++) begin
      add_row("len15", (k == 0) ? 1 : 0, 15, 500 + 211 * k, -400 - 97 * k, (k == 9) ? 1 : 0);
    end
    add_row("len0", 1, 0, 160, -160, 0);
    add_row("len0", 0, 0, 328, 17, 0);
    add_row("len0", 0, 0, -4000, 4000, 1);
    add_row("round_half", 1, 1, 8, -8, 0);  // exact halves
    add_row("round_half", 0, 1, 24, -24, 0);
    add_row("round_half", 0, 1, -9, 7, 0);
    add_row("round_half", 0, 1, 40, -40, 1);
    add_row("round_half", 0, 1, -8, 8, 0);
    for (int k = 0; k < 15; k++) begin  // sums close to full scale
      add_row("sat_pos_neg", (k == 0) ? 1 : 0, 15, 32767, -32768, (k == 14) ? 1 : 0);
    end
    for (int k = 0; k < 4; k++) begin
      add_row("sat_swing", 0, 15, -32768, 32767, (k == 2) ? 1 : 0);
    end
    add_row("latency", 1, 3, 1234, -4321, 1);  // kept last
  endtask

  function automatic sample_t scale_and_saturate(input int sum);
    int v;
    v = (sum + 8) >>> 4;
    if (v > 32767) begin
      v = 32767;
    end else if (v < -32768) begin
      v = -32768;
    end
    return sample_t'(v);
  endfunction

  // reference model of one table row
  task automatic model_row(input int r);
    int n;
    int first;
    int s_i;
    int s_q;
    if (tbl_clr[r]) begin
      mdl_i.delete();
      mdl_q.delete();
      mdl_len = int'(tbl_len[r]);
      if (mdl_len == 0) begin
        mdl_len = 1;
      end
    end
    mdl_i.push_back(int'(tbl_i[r]));
    mdl_q.push_back(int'(tbl_q[r]));
    n = mdl_i.size();
    first = (n > mdl_len) ? n - mdl_len : 0;
    s_i = 0;
    s_q = 0;
    for (int j = first; j < n; j++) begin
      s_i += mdl_i[j];
      s_q += mdl_q[j];
    end
    exp_name.push_back(tbl_name[r]);
    exp_i.push_back(scale_and_saturate(s_i));
    exp_q.push_back(scale_and_saturate(s_q));
    exp_last.push_back(tbl_last[r]);
  endtask

  // present one row and wait for the input handshake
  task automatic apply_row(input int r);
    logic taken;
    if (tbl_clr[r]) begin
      i_in_tvalid = 1'b0;
      i_clear = 1'b1;
      i_len = tbl_len[r];
      @(posedge i_clk);
      #5;
      i_clear = 1'b0;
    end
    i_in_tvalid = 1'b1;
    i_in_tlast = tbl_last[r];
    i_in_idata = tbl_i[r];
    i_in_qdata = tbl_q[r];
    taken = 1'b0;
    while (!taken) begin
      @(negedge i_clk);
      taken = o_in_tready;
      @(posedge i_clk);
    end
    #5;
    acc_cyc = cycle;
    i_in_tvalid = 1'b0;
  endtask

  always @(posedge i_clk) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_lim) begin
      abort_run($sformatf("Timeout: run still busy after %0d cycles", cycle));
    end
  end

  // output ready, random only in the back-pressure pass
  always @(posedge i_clk) begin
    if (bp_en) begin
      #5;
      lcg_state = lcg_next(lcg_state);
      i_out_tready = lcg_state[20] | lcg_state[17];
    end else begin
      #5;
      i_out_tready = 1'b1;
    end
  end

  // output monitor, checks by order only
  always @(negedge i_clk) begin
    if (!i_rst && o_out_tvalid && i_out_tready) begin
      if (exp_i.size() == 0) begin
        abort_run("Output sample appeared with no expected sample left");
      end else begin
        mon_name = exp_name.pop_front();
        mon_i = exp_i.pop_front();
        mon_q = exp_q.pop_front();
        mon_last = exp_last.pop_front();
        check_sample({mon_name, " I"}, mon_i, o_out_idata);
        check_sample({mon_name, " Q"}, mon_q, o_out_qdata);
        check_last({mon_name, " last"}, mon_last, o_out_tlast);
      end
    end
  end

  initial begin
    i_rst = 1'b1;
    i_clear = 1'b0;
    i_len = '0;
    i_in_tvalid = 1'b0;
    i_in_tlast = 1'b0;
    i_in_idata = '0;
    i_in_qdata = '0;
    i_out_tready = 1'b1;
    build_table();
    timeout_lim = 4 * (2 * (n_rows - 1) + 1) + 50;
    for (int p = 0; p < 2; p++) begin  // same sequence twice
      for (int r = 0; r < n_rows - 1; r++) begin
        model_row(r);
      end
    end
    model_row(n_rows - 1);

    repeat (4) @(posedge i_clk);
    #5;
    i_rst = 1'b0;

    for (int r = 0; r < n_rows - 1; r++) begin
      apply_row(r);
    end
    bp_en = 1'b1;
    for (int r = 0; r < n_rows - 1; r++) begin
      apply_row(r);
    end
    bp_en = 1'b0;

    do begin  // drain before the single-sample latency row
      @(posedge i_clk);
    end while (exp_i.size() > 1);
    #5;
    apply_row(n_rows - 1);
    @(negedge i_clk);
    while (!o_out_tvalid) begin
      @(negedge i_clk);
    end
    check_cycle("latency", acc_cyc + 2, cycle + 1);  // valid sampled at the next edge

    while (exp_i.size() > 0) begin
      @(posedge i_clk);
    end
    repeat (5) @(posedge i_clk);  // catch duplicated samples
    $display("Simulation passed");
    $finish;
  end

endmodule

// File: verilog/cmoving_avg.sv
`timescale 1ns/1ps

module cmoving_avg import cavg_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst,
  input  logic    i_clear,
  input  len_t    i_len,
  input  logic    i_in_tvalid,
  input  logic    i_in_tlast,
  input  sample_t i_in_idata,
  input  sample_t i_in_qdata,
  output logic    o_in_tready,
  output logic    o_out_tvalid,
  output logic    o_out_tlast,
  output sample_t o_out_idata,
  output sample_t o_out_qdata,
  input  logic    i_out_tready
);

  sum_t i_sum;
  sum_t q_sum;
  logic i_sum_tlast, i_sum_tvalid, i_rc_tready;
  logic q_sum_tlast, q_sum_tvalid, q_rc_tready;
  logic q_in_tready;
  logic q_out_tvalid, q_out_tlast;

  moving_sum u_i_sum (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_clear  (i_clear),
    .i_len    (i_len),
    .i_tdata  (i_in_idata),
    .i_tlast  (i_in_tlast),
    .i_tvalid (i_in_tvalid),
    .o_tready (o_in_tready),
    .o_tdata  (i_sum),
    .o_tlast  (i_sum_tlast),
    .o_tvalid (i_sum_tvalid),
    .i_tready (i_rc_tready)
  );

  moving_sum u_q_sum (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_clear  (i_clear),
    .i_len    (i_len),
    .i_tdata  (i_in_qdata),
    .i_tlast  (i_in_tlast),
    .i_tvalid (i_in_tvalid),
    .o_tready (q_in_tready),  // checked against the I rail only
    .o_tdata  (q_sum),
    .o_tlast  (q_sum_tlast),
    .o_tvalid (q_sum_tvalid),
    .i_tready (q_rc_tready)
  );

  round_clip u_i_rc (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_tdata  (i_sum),
    .i_tlast  (i_sum_tlast),
    .i_tvalid (i_sum_tvalid),
    .o_tready (i_rc_tready),
    .o_tdata  (o_out_idata),
    .o_tlast  (o_out_tlast),
    .o_tvalid (o_out_tvalid),
    .i_tready (i_out_tready)
  );

  round_clip u_q_rc (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_tdata  (q_sum),
    .i_tlast  (q_sum_tlast),
    .i_tvalid (q_sum_tvalid),
    .o_tready (q_rc_tready),
    .o_tdata  (o_out_qdata),
    .o_tlast  (q_out_tlast),
    .o_tvalid (q_out_tvalid),
    .i_tready (i_out_tready)
  );

  // both rails see the same handshakes, so they must move in lockstep
  a_in_ready_lock : assert property (@(posedge i_clk) disable iff (i_rst)
    o_in_tready == q_in_tready)
    else $error("cmoving_avg: input ready differs between rails");

  a_sum_lock : assert property (@(posedge i_clk) disable iff (i_rst)
    (i_sum_tvalid == q_sum_tvalid) && (i_rc_tready == q_rc_tready) &&
    (!i_sum_tvalid || (i_sum_tlast == q_sum_tlast)))
    else $error("cmoving_avg: sum stage out of lockstep");

  a_out_lock : assert property (@(posedge i_clk) disable iff (i_rst)
    (o_out_tvalid == q_out_tvalid) && (!o_out_tvalid || (o_out_tlast == q_out_tlast)))
    else $error("cmoving_avg: output stage out of lockstep");

endmodule

// File: verilog/round_clip.sv
`timescale 1ns/1ps

module round_clip import cavg_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst,
  input  sum_t    i_tdata,
  input  logic    i_tlast,
  input  logic    i_tvalid,
  output logic    o_tready,
  output sample_t o_tdata,
  output logic    o_tlast,
  output logic    o_tvalid,
  input  logic    i_tready
);

  logic signed [SUM_W:0]             rnd_sum;  // one guard bit for +half
  logic signed [SUM_W-SCALE_SHIFT:0] shifted;
  logic [SUM_W-SCALE_SHIFT:SAMPLE_W-1] top_bits;
  logic    ovf;
  sample_t sat_data;
  logic    accept;

  assign o_tready = !o_tvalid || i_tready;
  assign accept   = i_tvalid && o_tready;

  // round half up then drop SCALE_SHIFT bits
  assign rnd_sum = {i_tdata[SUM_W-1], i_tdata} + (SUM_W+1)'(2 ** (SCALE_SHIFT - 1));
  assign shifted = rnd_sum[SUM_W:SCALE_SHIFT];  // same bits as >>> SCALE_SHIFT

  // fits a sample only if all bits above the sample msb match it
  assign top_bits = shifted[SUM_W-SCALE_SHIFT:SAMPLE_W-1];
  assign ovf      = !((&top_bits) || !(|top_bits));

  always_comb begin
    if (!ovf) begin
      sat_data = shifted[SAMPLE_W-1:0];
    end else if (shifted[SUM_W-SCALE_SHIFT]) begin
      sat_data = {1'b1, {(SAMPLE_W-1){1'b0}}};  // most negative
    end else begin
      sat_data = {1'b0, {(SAMPLE_W-1){1'b1}}};  // most positive
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_tvalid <= 1'b0;
    end else if (o_tready) begin
      o_tvalid <= i_tvalid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_tdata <= sat_data;
      o_tlast <= i_tlast;
    end
  end

  // stalled output keeps valid, data and last
  a_hold_stall : assert property (@(posedge i_clk) disable iff (i_rst)
    o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata) && $stable(o_tlast))
    else $error("round_clip: output changed while stalled");

endmodule

// File: verilog/moving_sum.sv
`timescale 1ns/1ps

module moving_sum import cavg_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst,
  input  logic    i_clear,
  input  len_t    i_len,
  input  sample_t i_tdata,
  input  logic    i_tlast,
  input  logic    i_tvalid,
  output logic    o_tready,
  output sum_t    o_tdata,
  output logic    o_tlast,
  output logic    o_tvalid,
  input  logic    i_tready
);

  sample_t   hist [MAX_LEN];  // circular sample history
  hist_ptr_t wr_ptr;
  hist_ptr_t rd_ptr;
  len_t      fill_cnt;        // samples in window, saturates at len_q
  len_t      len_q;           // latched window length
  sum_t      acc;
  sum_t      acc_next;
  sample_t   old_sample;
  logic      accept;
  logic      full;

  assign o_tready = !o_tvalid || i_tready;
  assign accept   = i_tvalid && o_tready;
  assign full     = (fill_cnt == len_q);

  // len_q entries behind the write pointer, modulo MAX_LEN
  assign rd_ptr = wr_ptr - len_q + ((wr_ptr < len_q) ? hist_ptr_t'(MAX_LEN) : hist_ptr_t'(0));

  assign old_sample = hist[rd_ptr];  // read before this cycle's write

  assign acc_next = acc + sum_t'(i_tdata) - (full ? sum_t'(old_sample) : sum_t'(0));

  always_ff @(posedge i_clk) begin
    if (accept) begin
      hist[wr_ptr] <= i_tdata;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr   <= '0;
      fill_cnt <= '0;
      len_q    <= len_t'(1);
      acc      <= '0;
    end else if (i_clear) begin
      wr_ptr   <= '0;
      fill_cnt <= '0;
      len_q    <= (i_len == '0) ? len_t'(1) : i_len;  // len 0 acts as len 1
      acc      <= '0;
    end else if (accept) begin
      acc <= acc_next;
      if (wr_ptr == hist_ptr_t'(MAX_LEN - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + hist_ptr_t'(1);
      end
      if (!full) begin
        fill_cnt <= fill_cnt + len_t'(1);
      end
    end
  end

  // one-entry output stage
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_tvalid <= 1'b0;
    end else if (o_tready) begin
      o_tvalid <= i_tvalid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_tdata <= acc_next;
      o_tlast <= i_tlast;
    end
  end

  // the oldest sample is only dropped once the window has filled
  a_fill_le_len : assert property (@(posedge i_clk) disable iff (i_rst)
    fill_cnt <= len_q)
    else $error("moving_sum: fill count %0d above length %0d", fill_cnt, len_q);

endmodule

// File: verilog/cavg_pkg.sv
package cavg_pkg;

  // sample and window geometry
  localparam int SAMPLE_W    = 16;
  localparam int MAX_LEN     = 15;
  localparam int LEN_W       = 4;
  localparam int SUM_W       = SAMPLE_W + LEN_W;  // 15 full-scale samples fit
  localparam int SCALE_SHIFT = 4;                 // fixed divide by 16

  // one IQ rail sample
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // window length, 0 is read as 1
  typedef logic [LEN_W-1:0] len_t;

  // running window sum
  typedef logic signed [SUM_W-1:0] sum_t;

  // history buffer index
  typedef logic [LEN_W-1:0] hist_ptr_t;

endpackage
